/* design/ahb_om_consts.svh */
`ifndef AHB_OM_CONSTS_SVH
`define AHB_OM_CONSTS_SVH

// --------------------------------------------------------------------
// Output stage dimensions
// --------------------------------------------------------------------
`define AHB_OM_NUM_PORTS 3   // Input ports sharing the slave

// Bus widths
`define AHB_OM_ADDR_W    32  // HADDR
`define AHB_OM_DATA_W    32  // HWDATA
`define AHB_OM_PROT_W    4   // HPROT
`define AHB_OM_MASTER_W  4   // HMASTER
`define AHB_OM_SIZE_W    3   // HSIZE
`define AHB_OM_BURST_W   3   // HBURST

// Round-robin pointer after reset
// Pointing at the last port makes port 0 the first winner
`define AHB_OM_RST_PTR   2

`endif

/* design/ahb_om_pkg.sv */
`default_nettype none

// --------------------------------------------------------------------
// Shared types of the output stage
// --------------------------------------------------------------------
package ahb_om_pkg;

  // AHB HTRANS encoding
  typedef enum logic [1:0]
  {
    IDLE   = 2'b00,   // No transfer
    BUSY   = 2'b01,   // Burst paused by master
    NONSEQ = 2'b10,   // First beat or single
    SEQ    = 2'b11    // Burst continuation
  } htrans_t;

  // Input port number, 0 to 2
  typedef logic [1:0] port_idx_t;

endpackage

`default_nettype wire

/* design/ahb_om_arbiter.sv */
`default_nettype none
`timescale 1ns/100ps

`include "ahb_om_consts.svh"

module ahb_om_arbiter
(
  input  wire                  HCLK,                            // AHB clock
  input  wire                  HRESETn,                         // Sync reset, active low
  input  wire                  i_hready,                        // Transfer boundary strobe
  input  wire                  i_hsel      [`AHB_OM_NUM_PORTS], // Per-port select
  input  wire                  i_held_tran [`AHB_OM_NUM_PORTS], // Per-port held transfer
  input  wire ahb_om_pkg::htrans_t i_htrans [`AHB_OM_NUM_PORTS], // Per-port HTRANS
  input  wire                  i_hlock_arb,                     // Masked lock from routing
  output ahb_om_pkg::port_idx_t o_addr_in_port,                 // Granted port
  output logic                 o_no_port                        // No port granted
);

  import ahb_om_pkg::*;

  logic [`AHB_OM_NUM_PORTS-1:0] req;        // Port requests
  logic                         gnt_burst;  // Granted port continues a burst
  logic                         hold_grant; // Keep current owner
  port_idx_t                    next_port;  // Pre-registered grant
  logic                         next_none;  // Pre-registered no_port

  // --------------------------------------------------------------------
  // Request decode
  // --------------------------------------------------------------------
  always_comb
  begin
    for (int i = 0; i < `AHB_OM_NUM_PORTS; i++)
      req[i] = i_held_tran[i] & i_hsel[i];   // Held transfer aimed at this slave
  end

  // SEQ or BUSY from the owner means the burst is not finished
  assign gnt_burst = req[o_addr_in_port] &
                     ((i_htrans[o_addr_in_port] == SEQ) ||
                      (i_htrans[o_addr_in_port] == BUSY));

  // Locked sequence or running burst keeps the bus
  assign hold_grant = ~o_no_port & (i_hlock_arb | gnt_burst);

  // --------------------------------------------------------------------
  // Round-robin search
  // --------------------------------------------------------------------
  always_comb
  begin : p_next_grant
    int cand;                                 // Candidate port number

    next_port = o_addr_in_port;               // Pointer kept by default
    next_none = 1'b1;
    cand      = 0;

    if (hold_grant)
      next_none = 1'b0;                       // Same owner, same pointer
    else
    begin
      // Start just after the last owner, wrap around, owner checked last
      for (int off = 1; off <= `AHB_OM_NUM_PORTS; off++)
      begin
        cand = (int'(o_addr_in_port) + off) % `AHB_OM_NUM_PORTS;
        if (next_none && req[cand])
        begin
          next_port = port_idx_t'(cand);      // First requester wins
          next_none = 1'b0;
        end
      end
    end
  end

  // --------------------------------------------------------------------
  // Grant register
  // --------------------------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      o_addr_in_port <= port_idx_t'(`AHB_OM_RST_PTR); // Port 0 first
      o_no_port      <= 1'b1;                          // Nobody owns the slave
    end
    else if (i_hready)
    begin
      o_addr_in_port <= next_port;   // Only at transfer boundaries
      o_no_port      <= next_none;
    end
  end

  // Grant pointer stays inside the port range on every cycle
  a_port_range : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    o_addr_in_port <= port_idx_t'(`AHB_OM_NUM_PORTS - 1)
  );

endmodule

`default_nettype wire

/* design/ahb_om_addr_mux.sv */
`default_nettype none
`timescale 1ns/100ps

`include "ahb_om_consts.svh"

module ahb_om_addr_mux
(
  input  wire                          HCLK,                          // AHB clock
  input  wire                          HRESETn,                       // Sync reset, active low
  input  wire                          i_hready,                      // Transfer boundary
  input  wire ahb_om_pkg::port_idx_t   i_addr_in_port,                // Granted port
  input  wire                          i_no_port,                     // No grant
  input  wire                          i_hsel      [`AHB_OM_NUM_PORTS],
  input  wire [`AHB_OM_ADDR_W-1:0]     i_haddr     [`AHB_OM_NUM_PORTS],
  input  wire ahb_om_pkg::htrans_t     i_htrans    [`AHB_OM_NUM_PORTS],
  input  wire                          i_hwrite    [`AHB_OM_NUM_PORTS],
  input  wire [`AHB_OM_SIZE_W-1:0]     i_hsize     [`AHB_OM_NUM_PORTS],
  input  wire [`AHB_OM_BURST_W-1:0]    i_hburst    [`AHB_OM_NUM_PORTS],
  input  wire [`AHB_OM_PROT_W-1:0]     i_hprot     [`AHB_OM_NUM_PORTS],
  input  wire [`AHB_OM_MASTER_W-1:0]   i_hmaster   [`AHB_OM_NUM_PORTS],
  input  wire                          i_hmastlock [`AHB_OM_NUM_PORTS],
  output logic                         o_hsel,                        // Slave select
  output logic [`AHB_OM_ADDR_W-1:0]    o_haddr,                       // Slave address
  output ahb_om_pkg::htrans_t          o_htrans,                      // Transfer type
  output logic                         o_hwrite,                      // Direction
  output logic [`AHB_OM_SIZE_W-1:0]    o_hsize,                       // Transfer size
  output logic [`AHB_OM_BURST_W-1:0]   o_hburst,                      // Burst type
  output logic [`AHB_OM_PROT_W-1:0]    o_hprot,                       // Protection
  output logic [`AHB_OM_MASTER_W-1:0]  o_hmaster,                     // Master ID
  output logic                         o_hmastlock,                   // Locked transfer
  output logic                         o_active    [`AHB_OM_NUM_PORTS], // Grant flags
  output logic                         o_hlock_arb                    // Lock for arbiter
);

  import ahb_om_pkg::*;

  logic [`AHB_OM_NUM_PORTS-1:0] active_bits;    // One-hot grant decode
  logic                         hsel_lock;      // Locked sequence in progress here
  logic                         lock_start;     // Selected locked NONSEQ/SEQ

  // --------------------------------------------------------------------
  // Address and control routing
  // --------------------------------------------------------------------
  always_comb
  begin
    o_hsel      = 1'b0;                       // Zeros when idle
    o_haddr     = '0;
    o_htrans    = IDLE;
    o_hwrite    = 1'b0;
    o_hsize     = '0;
    o_hburst    = '0;
    o_hprot     = '0;
    o_hmaster   = '0;
    o_hmastlock = 1'b0;
    if (!i_no_port)
    begin
      o_hsel      = i_hsel[i_addr_in_port];
      o_haddr     = i_haddr[i_addr_in_port];
      o_htrans    = i_htrans[i_addr_in_port];
      o_hwrite    = i_hwrite[i_addr_in_port];
      o_hsize     = i_hsize[i_addr_in_port];
      o_hburst    = i_hburst[i_addr_in_port];
      o_hprot     = i_hprot[i_addr_in_port];
      o_hmaster   = i_hmaster[i_addr_in_port];
      o_hmastlock = i_hmastlock[i_addr_in_port];
    end
  end

  // Active flags from the grant
  always_comb
  begin
    for (int i = 0; i < `AHB_OM_NUM_PORTS; i++)
    begin
      active_bits[i] = !i_no_port && (i_addr_in_port == port_idx_t'(i));
      o_active[i]    = active_bits[i];
    end
  end

  // --------------------------------------------------------------------
  // Lock tracking
  // --------------------------------------------------------------------
  // A locked master may leave this slave for a few transfers and come
  // back; the arbiter must still see the lock during those cycles
  assign lock_start = o_hsel & o_hmastlock &
                      ((o_htrans == NONSEQ) || (o_htrans == SEQ));

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      hsel_lock <= 1'b0;
    else if (i_hready)
    begin
      if (lock_start)
        hsel_lock <= 1'b1;                    // Sequence begun on this slave
      else if (!o_hmastlock)
        hsel_lock <= 1'b0;                    // Lock dropped
    end
  end

  // Lock counts only once it is aimed at this slave
  assign o_hlock_arb = o_hmastlock & (o_hsel | hsel_lock);

  // Grant decode from the arbiter gives at most one owner
  a_active_onehot : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    $onehot0(active_bits) && (!i_no_port || (active_bits == '0))
  );

endmodule

`default_nettype wire

/* design/ahb_om_data_stage.sv */
`default_nettype none
`timescale 1ns/100ps

`include "ahb_om_consts.svh"

module ahb_om_data_stage
(
  input  wire                        HCLK,                       // AHB clock
  input  wire                        HRESETn,                    // Sync reset, active low
  input  wire ahb_om_pkg::port_idx_t i_addr_in_port,             // Address-phase owner
  input  wire                        i_hsel_m,                   // Routed select
  input  wire [`AHB_OM_DATA_W-1:0]   i_hwdata [`AHB_OM_NUM_PORTS], // Per-port write data
  input  wire                        i_hreadyout,                // Slave ready feedback
  output logic [`AHB_OM_DATA_W-1:0]  o_hwdata,                   // Slave write data
  output logic                       o_hreadymux                 // Shared ready
);

  import ahb_om_pkg::*;

  port_idx_t data_in_port;   // Owner of the current data phase
  logic      slave_sel;      // Slave addressed in last accepted phase

  // --------------------------------------------------------------------
  // Data-phase registers
  // --------------------------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_in_port <= '0;
      slave_sel    <= 1'b0;                   // Ready high out of reset
    end
    else if (o_hreadymux)
    begin
      data_in_port <= i_addr_in_port;         // Address phase becomes data phase
      slave_sel    <= i_hsel_m;
    end
  end

  // Write data follows the port one phase behind the address
  assign o_hwdata = i_hwdata[data_in_port];

  // --------------------------------------------------------------------
  // Ready generation
  // --------------------------------------------------------------------
  // Slave stalls only the transfers it actually took
  assign o_hreadymux = slave_sel ? i_hreadyout : 1'b1;

  // Data-phase owner must not move while the slave waits
  a_data_port_hold : assert property (
    @(posedge HCLK) disable iff (!HRESETn)
    !o_hreadymux |=> $stable(data_in_port)
  );

endmodule

`default_nettype wire

/* design/ahb_om_output_stage.sv */
`default_nettype none
`timescale 1ns/100ps

`include "ahb_om_consts.svh"

module ahb_om_output_stage
(
  input  wire                          HCLK,                          // AHB clock
  input  wire                          HRESETn,                       // Sync reset, active low
  input  wire                          i_hsel      [`AHB_OM_NUM_PORTS],
  input  wire [`AHB_OM_ADDR_W-1:0]     i_haddr     [`AHB_OM_NUM_PORTS],
  input  wire ahb_om_pkg::htrans_t     i_htrans    [`AHB_OM_NUM_PORTS],
  input  wire                          i_hwrite    [`AHB_OM_NUM_PORTS],
  input  wire [`AHB_OM_SIZE_W-1:0]     i_hsize     [`AHB_OM_NUM_PORTS],
  input  wire [`AHB_OM_BURST_W-1:0]    i_hburst    [`AHB_OM_NUM_PORTS],
  input  wire [`AHB_OM_PROT_W-1:0]     i_hprot     [`AHB_OM_NUM_PORTS],
  input  wire [`AHB_OM_MASTER_W-1:0]   i_hmaster   [`AHB_OM_NUM_PORTS],
  input  wire                          i_hmastlock [`AHB_OM_NUM_PORTS],
  input  wire [`AHB_OM_DATA_W-1:0]     i_hwdata    [`AHB_OM_NUM_PORTS],
  input  wire                          i_held_tran [`AHB_OM_NUM_PORTS],
  input  wire                          i_hreadyout,                   // Slave ready
  output logic                         o_active    [`AHB_OM_NUM_PORTS], // Grant flags
  output logic                         o_hsel,
  output logic [`AHB_OM_ADDR_W-1:0]    o_haddr,
  output ahb_om_pkg::htrans_t          o_htrans,
  output logic                         o_hwrite,
  output logic [`AHB_OM_SIZE_W-1:0]    o_hsize,
  output logic [`AHB_OM_BURST_W-1:0]   o_hburst,
  output logic [`AHB_OM_PROT_W-1:0]    o_hprot,
  output logic [`AHB_OM_MASTER_W-1:0]  o_hmaster,
  output logic                         o_hmastlock,
  output logic [`AHB_OM_DATA_W-1:0]    o_hwdata,                      // Slave write data
  output logic                         o_hreadymux                    // Shared ready
);

  import ahb_om_pkg::*;

  port_idx_t addr_in_port;   // Current grant
  logic      no_port;        // Nobody granted
  logic      hlock_arb;      // Lock seen by the arbiter

  // --------------------------------------------------------------------
  // Arbitration
  // --------------------------------------------------------------------
  ahb_om_arbiter u_arbiter
  (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_hready       (o_hreadymux),
    .i_hsel         (i_hsel),
    .i_held_tran    (i_held_tran),
    .i_htrans       (i_htrans),
    .i_hlock_arb    (hlock_arb),
    .o_addr_in_port (addr_in_port),
    .o_no_port      (no_port)
  );

  // Address phase to the slave
  ahb_om_addr_mux u_addr_mux
  (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_hready       (o_hreadymux),
    .i_addr_in_port (addr_in_port),
    .i_no_port      (no_port),
    .i_hsel         (i_hsel),
    .i_haddr        (i_haddr),
    .i_htrans       (i_htrans),
    .i_hwrite       (i_hwrite),
    .i_hsize        (i_hsize),
    .i_hburst       (i_hburst),
    .i_hprot        (i_hprot),
    .i_hmaster      (i_hmaster),
    .i_hmastlock    (i_hmastlock),
    .o_hsel         (o_hsel),
    .o_haddr        (o_haddr),
    .o_htrans       (o_htrans),
    .o_hwrite       (o_hwrite),
    .o_hsize        (o_hsize),
    .o_hburst       (o_hburst),
    .o_hprot        (o_hprot),
    .o_hmaster      (o_hmaster),
    .o_hmastlock    (o_hmastlock),
    .o_active       (o_active),
    .o_hlock_arb    (hlock_arb)
  );

  // Data phase and ready
  ahb_om_data_stage u_data_stage
  (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_addr_in_port (addr_in_port),
    .i_hsel_m       (o_hsel),
    .i_hwdata       (i_hwdata),
    .i_hreadyout    (i_hreadyout),
    .o_hwdata       (o_hwdata),
    .o_hreadymux    (o_hreadymux)
  );

endmodule

`default_nettype wire

/* tests/ahb_om_checker.sv */
`default_nettype none
`timescale 1ns/100ps

`include "ahb_om_consts.svh"

module ahb_om_checker
(
  input  wire                        HCLK,
  input  wire                        HRESETn,
  input  wire                        i_active     [`AHB_OM_NUM_PORTS], // DUT grant flags
  input  wire                        i_hsel,
  input  wire [`AHB_OM_ADDR_W-1:0]   i_haddr,
  input  wire ahb_om_pkg::htrans_t   i_htrans,
  input  wire                        i_hwrite,
  input  wire [`AHB_OM_SIZE_W-1:0]   i_hsize,
  input  wire [`AHB_OM_BURST_W-1:0]  i_hburst,
  input  wire [`AHB_OM_PROT_W-1:0]   i_hprot,
  input  wire [`AHB_OM_MASTER_W-1:0] i_hmaster,
  input  wire                        i_hmastlock,
  input  wire [`AHB_OM_DATA_W-1:0]   i_hwdata,
  input  wire                        i_hreadymux,
  input  wire [`AHB_OM_ADDR_W-1:0]   i_port_addr   [`AHB_OM_NUM_PORTS],
  input  wire [`AHB_OM_DATA_W-1:0]   i_port_wdata  [`AHB_OM_NUM_PORTS],
  input  wire ahb_om_pkg::htrans_t   i_port_trans  [`AHB_OM_NUM_PORTS], // Per-port stimulus
  input  wire                        i_port_write  [`AHB_OM_NUM_PORTS],
  input  wire [`AHB_OM_SIZE_W-1:0]   i_port_size   [`AHB_OM_NUM_PORTS],
  input  wire [`AHB_OM_BURST_W-1:0]  i_port_burst  [`AHB_OM_NUM_PORTS],
  input  wire [`AHB_OM_PROT_W-1:0]   i_port_prot   [`AHB_OM_NUM_PORTS],
  input  wire [`AHB_OM_MASTER_W-1:0] i_port_master [`AHB_OM_NUM_PORTS],
  input  wire                        i_port_lock   [`AHB_OM_NUM_PORTS],
  input  wire                        i_row_valid,   // Table row applied this cycle
  input  wire                        i_row_last,
  input  wire [2:0]                  i_row_sel,     // Per-port select of the row
  input  wire [1:0]                  i_exp_next,    // Next-cycle grant where 3 means none
  input  wire                        i_exp_rdy,     // Shared ready this cycle
  output logic                       o_done,
  output int                         o_checks,
  output int                         o_mismatches,
  output int                         o_other_errors
);

  localparam logic [1:0] NO_GNT = 2'd3;

  logic [1:0] cur_gnt;      // Expected grant in this cycle
  logic [1:0] data_port;    // Expected data-phase owner
  logic       data_valid;   // Data-phase owner was a real grant
  logic       rst_checked;  // Reset state already compared

  initial
  begin : p_reset_wait
    int cnt;

    o_done         = 1'b0;
    o_checks       = 0;
    o_mismatches   = 0;
    o_other_errors = 0;
    cur_gnt        = NO_GNT;
    data_port      = 2'd0;
    data_valid     = 1'b0;
    rst_checked    = 1'b0;
    cnt            = 0;
    while (HRESETn !== 1'b1 && cnt < 50)
    begin
      @(posedge HCLK);
      cnt++;
    end
    if (HRESETn !== 1'b1)
    begin
      $display("Reset was never released");
      o_other_errors++;
    end
  end

  task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
    o_checks++;
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      o_mismatches++;
    end
  endtask

  // --------------------------------------------------------------------
  // Compare at the falling edge away from the driving edge
  // --------------------------------------------------------------------
  always @(negedge HCLK)
  begin
    // First falling edge out of reset still shows the reset values
    if (HRESETn === 1'b1 && !rst_checked)
    begin
      for (int i = 0; i < `AHB_OM_NUM_PORTS; i++)
        compare(32'(i_active[i]), 32'd0, $sformatf("o_active[%0d] after reset", i));
      compare(32'(i_hsel), 32'd0, "o_hsel after reset");
      compare(32'(i_hreadymux), 32'd1, "o_hreadymux after reset");
      rst_checked = 1'b1;
    end

    if (HRESETn && i_row_valid && !o_done)
    begin
      for (int i = 0; i < `AHB_OM_NUM_PORTS; i++)
        compare(32'(i_active[i]), 32'(cur_gnt == 2'(i)), $sformatf("o_active[%0d]", i));
      if (cur_gnt == NO_GNT)
      begin
        compare(32'(i_hsel), 32'd0, "o_hsel");
        compare(i_haddr, 32'd0, "o_haddr");
        compare(32'({i_htrans, i_hwrite, i_hsize, i_hburst, i_hprot, i_hmaster, i_hmastlock}),
                32'd0, "address control");
      end
      else
      begin
        compare(32'(i_hsel), 32'(i_row_sel[cur_gnt]), "o_hsel");
        compare(i_haddr, i_port_addr[cur_gnt], "o_haddr");
        compare(32'(i_htrans), 32'(i_port_trans[cur_gnt]), "o_htrans");
        compare(32'(i_hwrite), 32'(i_port_write[cur_gnt]), "o_hwrite");
        compare(32'(i_hsize), 32'(i_port_size[cur_gnt]), "o_hsize");
        compare(32'(i_hburst), 32'(i_port_burst[cur_gnt]), "o_hburst");
        compare(32'(i_hprot), 32'(i_port_prot[cur_gnt]), "o_hprot");
        compare(32'(i_hmaster), 32'(i_port_master[cur_gnt]), "o_hmaster");
        compare(32'(i_hmastlock), 32'(i_port_lock[cur_gnt]), "o_hmastlock");
      end
      compare(32'(i_hreadymux), 32'(i_exp_rdy), "o_hreadymux");
      if (data_valid)
        compare(i_hwdata, i_port_wdata[data_port], "o_hwdata");

      if (i_exp_rdy)                          // Accepted address phase moves on
      begin
        data_valid = (cur_gnt != NO_GNT);
        data_port  = cur_gnt;
      end
      cur_gnt = i_exp_next;
      if (i_row_last)
        o_done = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* tests/tb_ahb_om.sv */
`default_nettype none
`timescale 1ns/100ps

`include "ahb_om_consts.svh"

module tb_ahb_om;

  import ahb_om_pkg::*;

  localparam int NUM_ROWS = 23;              // Stimulus table length
  localparam int DONE_TIMEOUT = 20;          // Cycles to wait for the checker

  logic                         HCLK;
  logic                         HRESETn;
  logic                         hsel      [`AHB_OM_NUM_PORTS];
  logic [`AHB_OM_ADDR_W-1:0]    haddr     [`AHB_OM_NUM_PORTS];
  htrans_t                      htrans    [`AHB_OM_NUM_PORTS];
  logic                         hwrite    [`AHB_OM_NUM_PORTS];
  logic [`AHB_OM_SIZE_W-1:0]    hsize     [`AHB_OM_NUM_PORTS];
  logic [`AHB_OM_BURST_W-1:0]   hburst    [`AHB_OM_NUM_PORTS];
  logic [`AHB_OM_PROT_W-1:0]    hprot     [`AHB_OM_NUM_PORTS];
  logic [`AHB_OM_MASTER_W-1:0]  hmaster   [`AHB_OM_NUM_PORTS];
  logic                         hmastlock [`AHB_OM_NUM_PORTS];
  logic [`AHB_OM_DATA_W-1:0]    hwdata    [`AHB_OM_NUM_PORTS];
  logic                         held_tran [`AHB_OM_NUM_PORTS];
  logic                         hreadyout;

  logic                         active    [`AHB_OM_NUM_PORTS];
  logic                         o_hsel;
  logic [`AHB_OM_ADDR_W-1:0]    o_haddr;
  htrans_t                      o_htrans;
  logic                         o_hwrite;
  logic [`AHB_OM_SIZE_W-1:0]    o_hsize;
  logic [`AHB_OM_BURST_W-1:0]   o_hburst;
  logic [`AHB_OM_PROT_W-1:0]    o_hprot;
  logic [`AHB_OM_MASTER_W-1:0]  o_hmaster;
  logic                         o_hmastlock;
  logic [`AHB_OM_DATA_W-1:0]    o_hwdata;
  logic                         o_hreadymux;

  // Row info handed to the checker
  logic                         row_valid;
  logic                         row_last;
  logic [2:0]                   row_sel_now;
  logic [1:0]                   row_exp_next;
  logic                         row_exp_rdy;
  logic                         chk_done;
  int                           chk_count;
  int                           mismatch_count;
  int                           other_count;

  // --------------------------------------------------------------------
  // Stimulus table with bit i of each 3-bit field for port i
  // --------------------------------------------------------------------
  logic [2:0]  t_held [NUM_ROWS];
  logic [2:0]  t_sel  [NUM_ROWS];
  logic [2:0]  t_lock [NUM_ROWS];
  htrans_t     t_tr0  [NUM_ROWS];
  htrans_t     t_tr1  [NUM_ROWS];
  htrans_t     t_tr2  [NUM_ROWS];
  logic        t_rdy  [NUM_ROWS];           // Slave ready
  logic [1:0]  t_next [NUM_ROWS];           // Next-cycle grant where 3 means none
  logic        t_erdy [NUM_ROWS];           // Expected shared ready this cycle
  int          n_rows;
  integer      seed;

  task automatic add_row(input logic [2:0] held, input logic [2:0] sel,
                         input logic [2:0] lock, input htrans_t tr0,
                         input htrans_t tr1, input htrans_t tr2,
                         input logic rdy, input logic [1:0] nxt, input logic erdy);
    t_held[n_rows] = held;
    t_sel[n_rows]  = sel;
    t_lock[n_rows] = lock;
    t_tr0[n_rows]  = tr0;
    t_tr1[n_rows]  = tr1;
    t_tr2[n_rows]  = tr2;
    t_rdy[n_rows]  = rdy;
    t_next[n_rows] = nxt;
    t_erdy[n_rows] = erdy;
    n_rows++;
  endtask

  task automatic build_table;
    n_rows = 0;
    add_row(3'b000, 3'b000, 3'b000, IDLE, IDLE, IDLE, 1'b1, 2'd3, 1'b1);       // Reset state
    add_row(3'b100, 3'b100, 3'b000, IDLE, IDLE, NONSEQ, 1'b1, 2'd2, 1'b1);     // Single port
    add_row(3'b000, 3'b000, 3'b000, IDLE, IDLE, IDLE, 1'b1, 2'd3, 1'b1);
    add_row(3'b111, 3'b111, 3'b000, NONSEQ, NONSEQ, NONSEQ, 1'b1, 2'd0, 1'b1); // Round robin
    add_row(3'b111, 3'b111, 3'b000, NONSEQ, NONSEQ, NONSEQ, 1'b1, 2'd1, 1'b1);
    add_row(3'b111, 3'b111, 3'b000, NONSEQ, NONSEQ, NONSEQ, 1'b1, 2'd2, 1'b1);
    add_row(3'b111, 3'b111, 3'b000, NONSEQ, NONSEQ, NONSEQ, 1'b1, 2'd0, 1'b1);
    add_row(3'b111, 3'b111, 3'b000, SEQ, NONSEQ, NONSEQ, 1'b1, 2'd0, 1'b1);    // Burst hold
    add_row(3'b111, 3'b111, 3'b000, BUSY, NONSEQ, NONSEQ, 1'b1, 2'd0, 1'b1);
    add_row(3'b111, 3'b111, 3'b000, SEQ, NONSEQ, NONSEQ, 1'b1, 2'd0, 1'b1);
    add_row(3'b110, 3'b110, 3'b000, IDLE, NONSEQ, NONSEQ, 1'b1, 2'd1, 1'b1);
    add_row(3'b000, 3'b000, 3'b000, IDLE, IDLE, IDLE, 1'b1, 2'd3, 1'b1);
    add_row(3'b100, 3'b100, 3'b100, IDLE, IDLE, NONSEQ, 1'b1, 2'd2, 1'b1);     // Locked seq
    add_row(3'b111, 3'b111, 3'b100, NONSEQ, NONSEQ, NONSEQ, 1'b1, 2'd2, 1'b1);
    add_row(3'b111, 3'b011, 3'b100, NONSEQ, NONSEQ, NONSEQ, 1'b1, 2'd2, 1'b1); // Other slave
    add_row(3'b111, 3'b111, 3'b100, NONSEQ, NONSEQ, NONSEQ, 1'b1, 2'd2, 1'b1);
    add_row(3'b011, 3'b011, 3'b000, NONSEQ, NONSEQ, IDLE, 1'b1, 2'd0, 1'b1);   // Lock released
    add_row(3'b001, 3'b001, 3'b000, NONSEQ, IDLE, IDLE, 1'b0, 2'd0, 1'b1);     // Wait states
    add_row(3'b011, 3'b011, 3'b000, NONSEQ, NONSEQ, IDLE, 1'b0, 2'd0, 1'b0);
    add_row(3'b011, 3'b011, 3'b000, NONSEQ, NONSEQ, IDLE, 1'b0, 2'd0, 1'b0);
    add_row(3'b011, 3'b011, 3'b000, NONSEQ, NONSEQ, IDLE, 1'b1, 2'd1, 1'b1);
    add_row(3'b000, 3'b000, 3'b000, IDLE, IDLE, IDLE, 1'b1, 2'd3, 1'b1);
    add_row(3'b000, 3'b000, 3'b000, IDLE, IDLE, IDLE, 1'b1, 2'd3, 1'b1);
  endtask

  // --------------------------------------------------------------------
  // Clock, reset and row driver
  // --------------------------------------------------------------------
  initial
  begin
    HCLK = 1'b0;
    forever #10 HCLK = ~HCLK;                // 20 ns period
  end

  initial
  begin : p_stimulus
    int wait_cnt;

    seed         = 32'h09dcfa5b;
    HRESETn      = 1'b0;
    hreadyout    = 1'b1;
    row_valid    = 1'b0;
    row_last     = 1'b0;
    row_sel_now  = 3'b000;
    row_exp_next = 2'd3;
    row_exp_rdy  = 1'b1;
    for (int i = 0; i < `AHB_OM_NUM_PORTS; i++)
    begin
      haddr[i]     = {8'(i), 24'($random(seed))};  // Port number in top byte
      hwdata[i]    = {8'(i), 24'($random(seed))};
      hsel[i]      = 1'b0;
      htrans[i]    = IDLE;
      hwrite[i]    = i[0];
      hsize[i]     = 3'(i);                  // Byte, halfword, word
      hburst[i]    = 3'(i + 1);
      hprot[i]     = 4'(i + 3);
      hmaster[i]   = 4'(i);
      hmastlock[i] = 1'b0;
      held_tran[i] = 1'b0;
    end
    build_table();

    repeat (4) @(posedge HCLK);
    HRESETn <= 1'b1;

    for (int r = 0; r < n_rows; r++)
    begin
      @(posedge HCLK);
      for (int i = 0; i < `AHB_OM_NUM_PORTS; i++)
      begin
        held_tran[i] <= t_held[r][i];
        hsel[i]      <= t_sel[r][i];
        hmastlock[i] <= t_lock[r][i];
      end
      htrans[0]    <= t_tr0[r];
      htrans[1]    <= t_tr1[r];
      htrans[2]    <= t_tr2[r];
      hreadyout    <= t_rdy[r];
      row_sel_now  <= t_sel[r];
      row_exp_next <= t_next[r];
      row_exp_rdy  <= t_erdy[r];
      row_valid    <= 1'b1;
      row_last     <= (r == n_rows - 1);
    end
    @(posedge HCLK);
    row_valid <= 1'b0;

    wait_cnt = 0;
    while (!chk_done && wait_cnt < DONE_TIMEOUT)
    begin
      @(posedge HCLK);
      wait_cnt++;
    end

    if (!chk_done)
      $display("Checker did not finish the table in time");
    $display("Checks %0d, mismatches %0d, other errors %0d",
             chk_count, mismatch_count, other_count);
    if (chk_done && mismatch_count == 0 && other_count == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  // --------------------------------------------------------------------
  // DUT and checker
  // --------------------------------------------------------------------
  ahb_om_output_stage DUT
  (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .i_hsel (hsel), .i_haddr (haddr), .i_htrans (htrans), .i_hwrite (hwrite),
    .i_hsize (hsize), .i_hburst (hburst), .i_hprot (hprot), .i_hmaster (hmaster),
    .i_hmastlock (hmastlock), .i_hwdata (hwdata), .i_held_tran (held_tran),
    .i_hreadyout (hreadyout), .o_active (active), .o_hsel (o_hsel),
    .o_haddr (o_haddr), .o_htrans (o_htrans), .o_hwrite (o_hwrite),
    .o_hsize (o_hsize), .o_hburst (o_hburst), .o_hprot (o_hprot),
    .o_hmaster (o_hmaster), .o_hmastlock (o_hmastlock), .o_hwdata (o_hwdata),
    .o_hreadymux (o_hreadymux)
  );

  ahb_om_checker u_checker
  (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .i_active (active), .i_hsel (o_hsel), .i_haddr (o_haddr),
    .i_htrans (o_htrans), .i_hwrite (o_hwrite), .i_hsize (o_hsize),
    .i_hburst (o_hburst), .i_hprot (o_hprot), .i_hmaster (o_hmaster),
    .i_hmastlock (o_hmastlock),
    .i_hwdata (o_hwdata), .i_hreadymux (o_hreadymux),
    .i_port_addr (haddr), .i_port_wdata (hwdata),
    .i_port_trans (htrans), .i_port_write (hwrite), .i_port_size (hsize),
    .i_port_burst (hburst), .i_port_prot (hprot), .i_port_master (hmaster),
    .i_port_lock (hmastlock),
    .i_row_valid (row_valid), .i_row_last (row_last), .i_row_sel (row_sel_now),
    .i_exp_next (row_exp_next), .i_exp_rdy (row_exp_rdy),
    .o_done (chk_done), .o_checks (chk_count), .o_mismatches (mismatch_count),
    .o_other_errors (other_count)
  );

endmodule

`default_nettype wire

/* project.f */
+incdir+design
design/ahb_om_pkg.sv
design/ahb_om_arbiter.sv
design/ahb_om_addr_mux.sv
design/ahb_om_data_stage.sv
design/ahb_om_output_stage.sv
tests/ahb_om_checker.sv
tests/tb_ahb_om.sv

/* Makefile */
# Verilator build and run of the AHB output stage testbench

TOP = tb_ahb_om

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "No errors" sim.log

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
